// File: hw/hazard_ctrl.sv
/*
 * Data hazard control
 * Bypass selection from the id, ex and mem stages, and load-use detection
 */

`timescale 1ns/1ps

module hazard_ctrl (
  input  riscv_id_pkg::instr_u if_instr,
  input  riscv_id_pkg::stage_t id_now,
  input  riscv_id_pkg::stage_t ex_stage,
  input  riscv_id_pkg::stage_t mem_stage,
  output riscv_id_pkg::byp_t   next_byp,
  output logic                 load_hazard
);
  import riscv_id_pkg::*;

  logic [4:0] src_a;
  logic [4:0] src_b;
  logic       use_a;
  logic       use_b;
  logic [4:0] ld_rd;
  logic       ld_pending;

  // x0 never forwards since it always reads zero
  function automatic logic fwd_hit(input logic [4:0] src, input stage_t stg);
    return ~stg.bubble & writes_rd(stg.instr.r.opcode) & (|stg.instr.r.rd) &
           (src == stg.instr.r.rd);
  endfunction

  assign src_a = if_instr.r.rs1;
  assign src_b = if_instr.r.rs2;
  assign use_a = uses_rs1(if_instr.r.opcode);
  assign use_b = uses_rs2(if_instr.r.opcode);

  ////////////////////////////////////////
  // Bypass flags
  ////////////////////////////////////////
  // The id stage result arrives through ex, and so on down the pipe
  assign next_byp.ex_a  = use_a & fwd_hit(src_a, id_now);
  assign next_byp.ex_b  = use_b & fwd_hit(src_b, id_now);
  assign next_byp.mem_a = use_a & fwd_hit(src_a, ex_stage);
  assign next_byp.mem_b = use_b & fwd_hit(src_b, ex_stage);
  assign next_byp.wb_a  = use_a & fwd_hit(src_a, mem_stage);
  assign next_byp.wb_b  = use_b & fwd_hit(src_b, mem_stage);

  ////////////////////////////////////////
  // Load-use
  ////////////////////////////////////////
  // Youngest load wins
  always_comb begin
    if (id_now.instr.r.opcode == OPC_LOAD && !id_now.bubble) begin
      ld_pending = 1'b1;
      ld_rd      = id_now.instr.r.rd;
    end else if (ex_stage.instr.r.opcode == OPC_LOAD && !ex_stage.bubble) begin
      ld_pending = 1'b1;
      ld_rd      = ex_stage.instr.r.rd;
    end else begin
      ld_pending = 1'b0;
      ld_rd      = '0;
    end
  end

  assign load_hazard = ld_pending & ((use_a & (src_a == ld_rd)) | (use_b & (src_b == ld_rd)));

endmodule

// File: hw/id_stage.sv
/*
 * RV32 instruction decode stage
 * Decode pipeline registers with flush and stall sequencing
 */

`timescale 1ns/1ps

`include "riscv_id_defines.svh"

module id_stage (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    ex_stall,
  input  logic                    bu_flush,
  input  logic [`XLEN-1:0]        bu_nxt_pc,
  input  logic                    st_flush,
  input  logic [`XLEN-1:0]        st_nxt_pc,
  input  logic [`XLEN-1:0]        if_pc,
  input  riscv_id_pkg::instr_u    if_instr,
  input  logic                    if_bubble,
  input  riscv_id_pkg::st_state_t st,
  input  riscv_id_pkg::stage_t    ex_stage,
  input  riscv_id_pkg::stage_t    mem_stage,
  input  riscv_id_pkg::stage_t    wb_stage,
  input  logic [`XLEN-1:0]        wb_r,
  output logic [`XLEN-1:0]        id_pc,
  output riscv_id_pkg::instr_u    id_instr,
  output logic                    id_bubble,
  output logic [`EXC_SIZE-1:0]    id_exception,
  output riscv_id_pkg::operands_t id_operands,
  output riscv_id_pkg::byp_t      id_byp,
  output logic                    id_stall
);
  import riscv_id_pkg::*;

  logic                 stall;
  logic                 flush;
  logic                 bubble_r;
  logic                 load_hazard;
  logic [`EXC_SIZE-1:0] next_exception;
  operands_t            next_operands;
  byp_t                 next_byp;
  stage_t               id_now;

  assign stall = ex_stall;
  assign flush = bu_flush | st_flush;

  instr_check u_instr_check (
    .if_instr       (if_instr),
    .if_bubble      (if_bubble),
    .st             (st),
    .next_exception (next_exception)
  );

  operand_select u_operand_select (
    .if_instr      (if_instr),
    .if_pc         (if_pc),
    .wb_r          (wb_r),
    .wb_stage      (wb_stage),
    .next_operands (next_operands)
  );

  // Instruction currently held in decode
  assign id_now.instr  = id_instr;
  assign id_now.bubble = id_bubble;

  hazard_ctrl u_hazard_ctrl (
    .if_instr    (if_instr),
    .id_now      (id_now),
    .ex_stage    (ex_stage),
    .mem_stage   (mem_stage),
    .next_byp    (next_byp),
    .load_hazard (load_hazard)
  );

  ////////////////////////////////////////
  // Stall and bubble
  ////////////////////////////////////////
  always_comb begin
    if (flush) begin
      id_stall = 1'b0;
    end else if (stall) begin
      // Nothing to hold when IF offers a bubble
      id_stall = ~if_bubble;
    end else begin
      id_stall = load_hazard;
    end
  end

  assign id_bubble = bubble_r | stall | flush;

  ////////////////////////////////////////
  // Decode registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_pc <= `PC_INIT;
    end else if (st_flush) begin
      id_pc <= st_nxt_pc;
    end else if (bu_flush) begin
      id_pc <= bu_nxt_pc;
    end else if (!stall && !id_stall) begin
      id_pc <= if_pc;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bubble_r     <= 1'b1;
      id_exception <= '0;
    end else if (flush) begin
      bubble_r     <= 1'b1;
      id_exception <= '0;
    end else if (!stall) begin
      // Load-use inserts a bubble behind the load
      bubble_r     <= id_stall | if_bubble;
      id_exception <= id_stall ? '0 : next_exception;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      id_byp <= '0;
    end else if (!stall) begin
      id_byp <= next_byp;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      id_instr    <= if_instr;
      id_operands <= next_operands;
    end
  end

endmodule

// File: hw/instr_check.sv
/*
 * Instruction legality check
 * Flags illegal RV32I encodings, CSR privilege violations,
 * ECALL and EBREAK for the instruction entering decode
 */

`timescale 1ns/1ps

`include "riscv_id_defines.svh"

module instr_check (
  input  riscv_id_pkg::instr_u    if_instr,
  input  logic                    if_bubble,
  input  riscv_id_pkg::st_state_t st,
  output logic [`EXC_SIZE-1:0]    next_exception
);
  import riscv_id_pkg::*;

  localparam bit HAS_U = (`HAS_U != 0);
  localparam bit HAS_S = (`HAS_S != 0);

  logic [11:0] csr_addr;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        s_ill;
  logic        sys_ill;
  logic        csr_rd_ill;
  logic        csr_wr_ill;
  logic        illegal;
  logic        is_ecall;

  // Counter read below machine mode needs the enable bits
  function automatic logic cnt_ill(input prv_e prv, input logic men, input logic sen);
    return (prv != PRV_M) & (~men | ((prv == PRV_U) & HAS_S & ~sen));
  endfunction

  assign csr_addr = if_instr.i.imm12;
  assign f3       = if_instr.r.funct3;
  assign f7       = if_instr.r.funct7;
  assign s_ill    = !HAS_S || (st.prv < PRV_S);
  assign is_ecall = (if_instr == ECALL);

  ////////////////////////////////////////
  // CSR access rules
  ////////////////////////////////////////
  always_comb begin
    case (csr_addr)
      CSR_CYCLE, CSR_CYCLEH:
        csr_rd_ill = cnt_ill(st.prv, st.mcnt_cy, st.scnt_cy);
      CSR_INSTRET, CSR_INSTRETH:
        csr_rd_ill = cnt_ill(st.prv, st.mcnt_ir, st.scnt_ir);
      // Timer lives outside the core
      CSR_TIME, CSR_TIMEH:
        csr_rd_ill = 1'b1;
      CSR_SSTATUS, CSR_SIE, CSR_STVEC, CSR_SCOUNTEREN, CSR_SSCRATCH,
      CSR_SEPC, CSR_SCAUSE, CSR_STVAL, CSR_SIP:
        csr_rd_ill = s_ill;
      CSR_SATP:
        csr_rd_ill = s_ill || (st.prv == PRV_S && st.tvm);
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID, CSR_MSTATUS,
      CSR_MISA, CSR_MEDELEG, CSR_MIDELEG, CSR_MIE, CSR_MTVEC, CSR_MCOUNTEREN,
      CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MCYCLE,
      CSR_MINSTRET, CSR_MCYCLEH, CSR_MINSTRETH:
        csr_rd_ill = (st.prv != PRV_M);
      default:
        csr_rd_ill = 1'b1;
    endcase
  end

  // Address bits 11:10 set means read-only
  assign csr_wr_ill = csr_rd_ill | (csr_addr[11:10] == 2'b11);

  // Privileged returns and environment calls
  always_comb begin
    case (if_instr)
      ECALL, EBREAK: sys_ill = 1'b0;
      URET:          sys_ill = !HAS_U;
      SRET:          sys_ill = s_ill || (st.prv == PRV_S && st.tsr);
      MRET:          sys_ill = (st.prv != PRV_M);
      default:       sys_ill = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Base instruction set
  ////////////////////////////////////////
  always_comb begin
    case (if_instr.r.opcode)
      OPC_LUI, OPC_AUIPC, OPC_JAL: illegal = 1'b0;
      OPC_JALR, OPC_MISC_MEM:      illegal = |f3;
      OPC_BRANCH:                  illegal = (f3[2:1] == 2'b01);
      OPC_LOAD:                    illegal = (f3 == 3'b011) || (f3[2:1] == 2'b11);
      OPC_STORE:                   illegal = f3[2] || (f3[1:0] == 2'b11);
      OPC_OP_IMM: begin
        // Shift amount fits in 5 bits
        if (f3 == 3'b001) begin
          illegal = |f7;
        end else if (f3 == 3'b101) begin
          illegal = (f7 != 7'b000_0000) && (f7 != 7'b010_0000);
        end else begin
          illegal = 1'b0;
        end
      end
      OPC_OP: begin
        // SUB and SRA are the only alternate forms
        illegal = !((f7 == 7'b000_0000) ||
                    (f7 == 7'b010_0000 && (f3 == 3'b000 || f3 == 3'b101)));
      end
      OPC_SYSTEM: begin
        case (f3)
          3'b000:  illegal = sys_ill;
          3'b100:  illegal = 1'b1;
          3'b001:  illegal = csr_rd_ill | csr_wr_ill;
          default: illegal = csr_rd_ill | (|if_instr.r.rs1 & csr_wr_ill);
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  always_comb begin
    next_exception = '0;
    if (!if_bubble) begin
      next_exception[CAUSE_ILLEGAL_INSTRUCTION] = illegal;
      next_exception[CAUSE_BREAKPOINT]          = (if_instr == EBREAK);
      next_exception[CAUSE_UMODE_ECALL]         = is_ecall && st.prv == PRV_U && HAS_U;
      next_exception[CAUSE_SMODE_ECALL]         = is_ecall && st.prv == PRV_S && HAS_S;
      next_exception[CAUSE_MMODE_ECALL]         = is_ecall && st.prv == PRV_M;
    end
  end

endmodule

// File: hw/operand_select.sv
/*
 * Operand formation
 * Builds the immediates and picks operands A/B and the register-file-use flags
 */

`timescale 1ns/1ps

`include "riscv_id_defines.svh"

module operand_select (
  input  riscv_id_pkg::instr_u    if_instr,
  input  logic [`XLEN-1:0]        if_pc,
  input  logic [`XLEN-1:0]        wb_r,
  input  riscv_id_pkg::stage_t    wb_stage,
  output riscv_id_pkg::operands_t next_operands
);
  import riscv_id_pkg::*;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic [4:0]       wb_rd;
  logic             can_ldwb;
  logic             wb_hit_a;
  logic             wb_hit_b;

  assign imm_i = {{(`XLEN-12){if_instr.i.imm12[11]}}, if_instr.i.imm12};
  assign imm_u = {if_instr.u.imm20, 12'h000};

  // Result sitting in wb_r, not yet in the register file
  assign wb_rd    = wb_stage.instr.r.rd;
  assign can_ldwb = ~wb_stage.bubble & writes_rd(wb_stage.instr.r.opcode) & |wb_rd;
  assign wb_hit_a = can_ldwb & (if_instr.r.rs1 == wb_rd);
  assign wb_hit_b = can_ldwb & (if_instr.r.rs2 == wb_rd);

  always_comb begin
    next_operands.userf_a = uses_rs1(if_instr.r.opcode) & ~wb_hit_a;
    next_operands.userf_b = uses_rs2(if_instr.r.opcode) & ~wb_hit_b;
    case (if_instr.r.opcode)
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
        next_operands.opa = wb_r;
        next_operands.opb = imm_i;
      end
      OPC_AUIPC: begin
        next_operands.opa = if_pc;
        next_operands.opb = imm_u;
      end
      OPC_LUI: begin
        next_operands.opa = '0;
        next_operands.opb = imm_u;
      end
      OPC_OP, OPC_BRANCH, OPC_STORE: begin
        next_operands.opa = wb_r;
        next_operands.opb = wb_r;
      end
      // CSR source, rs1 field doubles as the zimm
      OPC_SYSTEM: begin
        next_operands.opa = wb_r;
        next_operands.opb = {{(`XLEN-5){1'b0}}, if_instr.r.rs1};
      end
      OPC_JAL, OPC_MISC_MEM: begin
        next_operands.opa = '0;
        next_operands.opb = '0;
      end
      default: begin
        next_operands.opa     = '0;
        next_operands.opb     = '0;
        next_operands.userf_a = 1'b1;
        next_operands.userf_b = 1'b1;
      end
    endcase
  end

endmodule

// File: hw/riscv_id_defines.svh
/*
 * RV32 decode stage configuration
 * Data width, exception vector size, reset pc and privilege options
 */

`ifndef RISCV_ID_DEFINES_SVH
`define RISCV_ID_DEFINES_SVH

// Data path width
`define XLEN 32

// One bit per exception cause
`define EXC_SIZE 16

// Fetch address after reset
`define PC_INIT 32'h0000_0200

// Implemented privilege modes, machine mode is always present
`define HAS_U 1
`define HAS_S 1

`endif

// File: hw/riscv_id_pkg.sv
/*
 * RV32 decode package
 * Opcodes, causes, privilege levels, CSR map and the decode stage types
 */

`include "riscv_id_defines.svh"

package riscv_id_pkg;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_STORE    = 5'b01000,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_e;

  typedef enum logic [1:0] {
    PRV_U = 2'd0,
    PRV_S = 2'd1,
    PRV_M = 2'd3
  } prv_e;

  // Exception cause bit positions
  localparam int CAUSE_ILLEGAL_INSTRUCTION = 2;
  localparam int CAUSE_BREAKPOINT          = 3;
  localparam int CAUSE_UMODE_ECALL         = 8;
  localparam int CAUSE_SMODE_ECALL         = 9;
  localparam int CAUSE_MMODE_ECALL         = 11;

  // Fixed system encodings
  localparam logic [31:0] ECALL  = 32'h0000_0073;
  localparam logic [31:0] EBREAK = 32'h0010_0073;
  localparam logic [31:0] URET   = 32'h0020_0073;
  localparam logic [31:0] SRET   = 32'h1020_0073;
  localparam logic [31:0] MRET   = 32'h3020_0073;

  ////////////////////////////////////////
  // CSR addresses
  ////////////////////////////////////////
  localparam logic [11:0] CSR_CYCLE      = 12'hC00;
  localparam logic [11:0] CSR_TIME       = 12'hC01;
  localparam logic [11:0] CSR_INSTRET    = 12'hC02;
  localparam logic [11:0] CSR_CYCLEH     = 12'hC80;
  localparam logic [11:0] CSR_TIMEH      = 12'hC81;
  localparam logic [11:0] CSR_INSTRETH   = 12'hC82;

  localparam logic [11:0] CSR_SSTATUS    = 12'h100;
  localparam logic [11:0] CSR_SIE        = 12'h104;
  localparam logic [11:0] CSR_STVEC      = 12'h105;
  localparam logic [11:0] CSR_SCOUNTEREN = 12'h106;
  localparam logic [11:0] CSR_SSCRATCH   = 12'h140;
  localparam logic [11:0] CSR_SEPC       = 12'h141;
  localparam logic [11:0] CSR_SCAUSE     = 12'h142;
  localparam logic [11:0] CSR_STVAL      = 12'h143;
  localparam logic [11:0] CSR_SIP        = 12'h144;
  localparam logic [11:0] CSR_SATP       = 12'h180;

  localparam logic [11:0] CSR_MVENDORID  = 12'hF11;
  localparam logic [11:0] CSR_MARCHID    = 12'hF12;
  localparam logic [11:0] CSR_MIMPID     = 12'hF13;
  localparam logic [11:0] CSR_MHARTID    = 12'hF14;
  localparam logic [11:0] CSR_MSTATUS    = 12'h300;
  localparam logic [11:0] CSR_MISA       = 12'h301;
  localparam logic [11:0] CSR_MEDELEG    = 12'h302;
  localparam logic [11:0] CSR_MIDELEG    = 12'h303;
  localparam logic [11:0] CSR_MIE        = 12'h304;
  localparam logic [11:0] CSR_MTVEC      = 12'h305;
  localparam logic [11:0] CSR_MCOUNTEREN = 12'h306;
  localparam logic [11:0] CSR_MSCRATCH   = 12'h340;
  localparam logic [11:0] CSR_MEPC       = 12'h341;
  localparam logic [11:0] CSR_MCAUSE     = 12'h342;
  localparam logic [11:0] CSR_MTVAL      = 12'h343;
  localparam logic [11:0] CSR_MIP        = 12'h344;
  localparam logic [11:0] CSR_MCYCLE     = 12'hB00;
  localparam logic [11:0] CSR_MINSTRET   = 12'hB02;
  localparam logic [11:0] CSR_MCYCLEH    = 12'hB80;
  localparam logic [11:0] CSR_MINSTRETH  = 12'hB82;

  ////////////////////////////////////////
  // Instruction views
  ////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
    logic [1:0] lsb;
  } r_fields_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
    logic [1:0]  lsb;
  } i_fields_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    opcode_e     opcode;
    logic [1:0]  lsb;
  } u_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
    u_fields_t u;
  } instr_u;

  // Instruction in flight in a later stage
  typedef struct packed {
    instr_u instr;
    logic   bubble;
  } stage_t;

  typedef struct packed {
    prv_e prv;
    logic tvm;
    logic tsr;
    logic mcnt_cy;
    logic mcnt_ir;
    logic scnt_cy;
    logic scnt_ir;
  } st_state_t;

  typedef struct packed {
    logic ex_a;
    logic ex_b;
    logic mem_a;
    logic mem_b;
    logic wb_a;
    logic wb_b;
  } byp_t;

  typedef struct packed {
    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic             userf_a;
    logic             userf_b;
  } operands_t;

  // Opcodes that leave a result in rd
  function automatic logic writes_rd(input opcode_e opc);
    case (opc)
      OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_OP, OPC_LUI, OPC_JAL, OPC_JALR, OPC_SYSTEM:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  function automatic logic uses_rs1(input opcode_e opc);
    case (opc)
      OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_BRANCH, OPC_JALR, OPC_SYSTEM:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  function automatic logic uses_rs2(input opcode_e opc);
    return (opc == OPC_OP) || (opc == OPC_BRANCH) || (opc == OPC_STORE);
  endfunction

endpackage

// File: project.f
+incdir+hw
hw/riscv_id_pkg.sv
hw/instr_check.sv
hw/operand_select.sv
hw/hazard_ctrl.sv
hw/id_stage.sv
tests/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module tb_id_stage -f project.f -o sim_id_stage

out=$(./obj_dir/sim_id_stage)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: tests/tb_id_stage.sv
/*
 * Testbench for the RV32 decode stage
 * Table of rows applied in a loop, checked against a small reference model
 */

`timescale 1ns/1ps

`include "riscv_id_defines.svh"

module tb_id_stage;
  import riscv_id_pkg::*;

  typedef struct packed {
    logic [31:0]      instr;
    logic [31:0]      pc;
    logic             bubble;
    st_state_t        st;
    stage_t           ex;
    stage_t           mem;
    stage_t           wb;
    logic [31:0]      wb_r;
    logic             ex_stall;
    logic             bu_flush;
    logic             st_flush;
    logic [31:0]      nxt_pc;
    logic [31:0]      st_pc;
    logic [15:0]      exp_exc;
    byp_t             exp_byp;
    logic             exp_stall;
  } row_t;

  logic clk = 1'b0;
  logic rstn;
  logic ex_stall, bu_flush, st_flush, if_bubble;
  logic [31:0] bu_nxt_pc, st_nxt_pc, if_pc, wb_r;
  instr_u if_instr;
  st_state_t st;
  stage_t ex_stage, mem_stage, wb_stage;
  logic [31:0] id_pc;
  instr_u id_instr;
  logic id_bubble;
  logic [`EXC_SIZE-1:0] id_exception;
  operands_t id_operands;
  byp_t id_byp;
  logic id_stall;

  row_t  rows[$];
  string names[$];
  row_t  cur;
  string cur_name;
  integer seed = 32'h5a29;
  int cycles = 0;
  int limit = 1000;
  int rows_ok = 0;
  int rows_bad = 0;
  bit row_bad;

  // Reference state of the decode registers
  logic [31:0] m_pc, m_instr;
  logic m_bub;
  logic [15:0] m_exc;
  byp_t m_byp;
  operands_t m_ops;

  id_stage DUT (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles", cycles);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic stage_t live_stage(input logic [31:0] w);
    stage_t s;
    s.instr  = w;
    s.bubble = 1'b0;
    return s;
  endfunction

  function automatic stage_t idle_stage();
    stage_t s;
    s.instr  = 32'h0;
    s.bubble = 1'b1;
    return s;
  endfunction

  // Opcodes whose result lands in rd
  function automatic logic has_rd(input logic [4:0] opc);
    case (opc)
      5'b00000, 5'b00100, 5'b00101, 5'b01100, 5'b01101, 5'b11011, 5'b11001, 5'b11100:
        return 1'b1;
      default:
        return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////
  // Operand model
  ////////////////////////////////////////
  function automatic operands_t ref_operands(input row_t r);
    operands_t o;
    logic [4:0] opc;
    logic [4:0] wrd;
    logic wb_ok;
    opc   = r.instr[6:2];
    wrd   = r.wb.instr[11:7];
    wb_ok = !r.wb.bubble && has_rd(r.wb.instr[6:2]) && (wrd != 5'd0);
    o = '0;
    case (opc)
      5'b00100, 5'b00000, 5'b11001: begin
        o.opa = r.wb_r;
        o.opb = {{20{r.instr[31]}}, r.instr[31:20]};
        o.userf_a = 1'b1;
      end
      5'b00101: begin
        o.opa = r.pc;
        o.opb = {r.instr[31:12], 12'h000};
      end
      5'b01101: o.opb = {r.instr[31:12], 12'h000};
      5'b01100, 5'b11000, 5'b01000: begin
        o.opa = r.wb_r;
        o.opb = r.wb_r;
        o.userf_a = 1'b1;
        o.userf_b = 1'b1;
      end
      5'b11100: begin
        o.opa = r.wb_r;
        o.opb = {27'h0, r.instr[19:15]};
        o.userf_a = 1'b1;
      end
      5'b11011, 5'b00011: o = '0;
      default: begin
        o.userf_a = 1'b1;
        o.userf_b = 1'b1;
        return o;
      end
    endcase
    // Source still in flight at wb reads from wb_r
    if (wb_ok && r.instr[19:15] == wrd) o.userf_a = 1'b0;
    if (wb_ok && r.instr[24:20] == wrd) o.userf_b = 1'b0;
    return o;
  endfunction

  task automatic start_row(input string name, input logic [31:0] instr);
    cur = '0;
    cur_name = name;
    cur.instr = instr;
    cur.pc = $random(seed);
    cur.wb_r = $random(seed);
    cur.nxt_pc = $random(seed);
    cur.st_pc = $random(seed);
    cur.st.prv = PRV_M;
    cur.st.mcnt_cy = 1'b1;
    cur.st.mcnt_ir = 1'b1;
    cur.st.scnt_cy = 1'b1;
    cur.st.scnt_ir = 1'b1;
    cur.ex = idle_stage();
    cur.mem = idle_stage();
    cur.wb = idle_stage();
  endtask

  task automatic push_row(input logic [15:0] exc, input logic [5:0] byp, input logic stl);
    cur.exp_exc = exc;
    cur.exp_byp = byp;
    cur.exp_stall = stl;
    rows.push_back(cur);
    names.push_back(cur_name);
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////
  task automatic build_table();
    start_row("addi", enc_i(12'hFFD, 5'd1, 3'b000, 5'd5, 7'h13));
    push_row(16'h0, 6'b0, 1'b0);
    start_row("lui", {20'h12345, 5'd6, 7'h37});
    push_row(16'h0, 6'b0, 1'b0);
    start_row("auipc", {20'hABCDE, 5'd7, 7'h17});
    push_row(16'h0, 6'b0, 1'b0);
    start_row("add_wb_hit", enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd8, 7'h33));
    cur.wb = live_stage(enc_i(12'h001, 5'd1, 3'b000, 5'd3, 7'h13));
    push_row(16'h0, 6'b0, 1'b0);
    start_row("csrrwi", enc_i(12'h340, 5'd5, 3'b101, 5'd9, 7'h73));
    push_row(16'h0, 6'b0, 1'b0);
    start_row("ebreak", 32'h0010_0073);
    push_row(16'h0008, 6'b0, 1'b0);
    start_row("ecall_s", 32'h0000_0073);
    cur.st.prv = PRV_S;
    push_row(16'h0200, 6'b0, 1'b0);
    start_row("ecall_u", 32'h0000_0073);
    cur.st.prv = PRV_U;
    push_row(16'h0100, 6'b0, 1'b0);
    start_row("undef_opcode", 32'h0000_007F);
    push_row(16'h0004, 6'b0, 1'b0);
    start_row("mret_u", 32'h3020_0073);
    cur.st.prv = PRV_U;
    push_row(16'h0004, 6'b0, 1'b0);
    start_row("bubble_in", 32'h0010_0073);
    cur.bubble = 1'b1;
    push_row(16'h0, 6'b0, 1'b0);
    start_row("mstatus_s", enc_i(12'h300, 5'd0, 3'b010, 5'd10, 7'h73));
    cur.st.prv = PRV_S;
    push_row(16'h0004, 6'b0, 1'b0);
    start_row("satp_tvm", enc_i(12'h180, 5'd0, 3'b010, 5'd10, 7'h73));
    cur.st.prv = PRV_S;
    cur.st.tvm = 1'b1;
    push_row(16'h0004, 6'b0, 1'b0);
    start_row("satp_ok", enc_i(12'h180, 5'd0, 3'b010, 5'd10, 7'h73));
    cur.st.prv = PRV_S;
    push_row(16'h0, 6'b0, 1'b0);
    start_row("time_read", enc_i(12'hC01, 5'd0, 3'b010, 5'd11, 7'h73));
    push_row(16'h0004, 6'b0, 1'b0);
    start_row("cycle_u_off", enc_i(12'hC00, 5'd0, 3'b010, 5'd11, 7'h73));
    cur.st.prv = PRV_U;
    cur.st.scnt_cy = 1'b0;
    push_row(16'h0004, 6'b0, 1'b0);
    start_row("cycle_u_on", enc_i(12'hC00, 5'd0, 3'b010, 5'd11, 7'h73));
    cur.st.prv = PRV_U;
    push_row(16'h0, 6'b0, 1'b0);
    start_row("mvendorid_wr", enc_i(12'hF11, 5'd1, 3'b001, 5'd12, 7'h73));
    push_row(16'h0004, 6'b0, 1'b0);
    start_row("producer", enc_i(12'h001, 5'd0, 3'b000, 5'd13, 7'h13));
    push_row(16'h0, 6'b0, 1'b0);
    // Sources hit id rd13 and ex rd15
    start_row("byp_id_ex", enc_r(7'h00, 5'd15, 5'd13, 3'b000, 5'd14, 7'h33));
    cur.ex = live_stage(enc_i(12'h002, 5'd1, 3'b000, 5'd15, 7'h13));
    push_row(16'h0, 6'b100100, 1'b0);
    start_row("byp_ex_mem", enc_r(7'h20, 5'd18, 5'd16, 3'b000, 5'd17, 7'h33));
    cur.ex = live_stage(enc_i(12'h003, 5'd1, 3'b000, 5'd18, 7'h13));
    cur.mem = live_stage(enc_i(12'h004, 5'd1, 3'b000, 5'd16, 7'h13));
    push_row(16'h0, 6'b000110, 1'b0);
    // Store in ex and bubble in mem
    start_row("byp_none", enc_r(7'h00, 5'd20, 5'd0, 3'b000, 5'd19, 7'h33));
    cur.ex = live_stage(enc_r(7'h00, 5'd5, 5'd1, 3'b010, 5'd20, 7'h23));
    cur.mem = live_stage(enc_i(12'h005, 5'd1, 3'b000, 5'd20, 7'h13));
    cur.mem.bubble = 1'b1;
    push_row(16'h0, 6'b0, 1'b0);
    start_row("byp_x0", enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd21, 7'h33));
    cur.ex = live_stage(enc_i(12'h006, 5'd0, 3'b000, 5'd0, 7'h13));
    push_row(16'h0, 6'b0, 1'b0);
    start_row("load", enc_i(12'h000, 5'd1, 3'b010, 5'd22, 7'h03));
    push_row(16'h0, 6'b0, 1'b0);
    start_row("load_use", enc_r(7'h00, 5'd0, 5'd22, 3'b000, 5'd23, 7'h33));
    push_row(16'h0, 6'b100000, 1'b1);
    start_row("bu_flush", enc_r(7'h00, 5'd0, 5'd22, 3'b000, 5'd23, 7'h33));
    cur.ex = live_stage(enc_i(12'h000, 5'd1, 3'b010, 5'd22, 7'h03));
    cur.bu_flush = 1'b1;
    push_row(16'h0, 6'b001000, 1'b0);
    start_row("st_flush", enc_i(12'h004, 5'd1, 3'b000, 5'd24, 7'h13));
    cur.st_flush = 1'b1;
    push_row(16'h0, 6'b0, 1'b0);
    start_row("pre_stall", enc_i(12'h007, 5'd2, 3'b000, 5'd25, 7'h13));
    push_row(16'h0, 6'b0, 1'b0);
    start_row("stall_busy", 32'h0010_0073);
    cur.ex_stall = 1'b1;
    push_row(16'h0, 6'b0, 1'b1);
    start_row("stall_idle", 32'h0010_0073);
    cur.ex_stall = 1'b1;
    cur.bubble = 1'b1;
    push_row(16'h0, 6'b0, 1'b0);
    start_row("post_stall", {20'h0F0F0, 5'd26, 7'h37});
    push_row(16'h0, 6'b0, 1'b0);
  endtask

  task automatic drive_row(input row_t r);
    if_instr = r.instr;
    if_pc = r.pc;
    if_bubble = r.bubble;
    st = r.st;
    ex_stage = r.ex;
    mem_stage = r.mem;
    wb_stage = r.wb;
    wb_r = r.wb_r;
    ex_stall = r.ex_stall;
    bu_flush = r.bu_flush;
    bu_nxt_pc = r.nxt_pc;
    st_flush = r.st_flush;
    st_nxt_pc = r.st_pc;
  endtask

  task automatic compare_field(input string name, input string field,
      input logic [127:0] exp, input logic [127:0] act);
    if (exp !== act) begin
      $display("error %s %s expected %0h actual %0h", name, field, exp, act);
      row_bad = 1'b1;
    end
  endtask

  // Model update for one row, then registered checks
  task automatic check_row(input int k);
    row_t r;
    logic flush;
    r = rows[k];
    flush = r.bu_flush | r.st_flush;
    if (r.st_flush) m_pc = r.st_pc;
    else if (r.bu_flush) m_pc = r.nxt_pc;
    else if (!r.ex_stall && !r.exp_stall) m_pc = r.pc;
    if (flush) begin
      m_bub = 1'b1;
      m_exc = '0;
    end else if (!r.ex_stall) begin
      m_bub = r.exp_stall | r.bubble;
      m_exc = r.exp_stall ? 16'h0 : r.exp_exc;
    end
    if (!r.ex_stall) begin
      m_byp = r.exp_byp;
      m_ops = ref_operands(r);
      m_instr = r.instr;
    end
    compare_field(names[k], "id_pc", 128'(m_pc), 128'(id_pc));
    compare_field(names[k], "id_instr", 128'(m_instr), 128'(id_instr));
    compare_field(names[k], "id_bubble", 128'(m_bub | r.ex_stall | flush), 128'(id_bubble));
    compare_field(names[k], "id_exception", 128'(m_exc), 128'(id_exception));
    compare_field(names[k], "id_byp", 128'(m_byp), 128'(id_byp));
    compare_field(names[k], "id_operands", 128'(m_ops), 128'(id_operands));
    if (row_bad) rows_bad++;
    else rows_ok++;
    $display("%-14s %s", names[k], row_bad ? "bad" : "ok");
  endtask

  initial begin
    int i;
    int n;
    cur = '0;
    start_row("idle", 32'h0);
    cur.bubble = 1'b1;
    drive_row(cur);
    rstn = 1'b0;
    build_table();
    n = rows.size();
    limit = n * 2 + 20;
    repeat (8) @(posedge clk);
    #1 rstn = 1'b1;
    m_pc = `PC_INIT;
    m_bub = 1'b1;
    m_exc = '0;
    row_bad = 1'b0;
    if (id_bubble !== 1'b1 || id_exception !== '0 || id_pc !== `PC_INIT || id_stall !== 1'b0) begin
      $display("Decode registers not in their reset state after reset");
      row_bad = 1'b1;
      rows_bad++;
    end else begin
      rows_ok++;
    end
    $display("%-14s %s", "reset", row_bad ? "bad" : "ok");
    for (i = 0; i <= n; i++) begin
      @(posedge clk);
      #1;
      if (i > 0) check_row(i - 1);
      if (i < n) begin
        row_bad = 1'b0;
        drive_row(rows[i]);
        @(negedge clk);
        compare_field(names[i], "id_stall", 128'(rows[i].exp_stall), 128'(id_stall));
      end
    end
    $display("Rows passed %0d, failed %0d", rows_ok, rows_bad);
    if (rows_bad == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
